//--- bpb_bank.sv
`timescale 1ns/1ps
`include "bpb_defines.svh"

module bpb_bank
(
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          stall,
    input  logic                          commit_valid,
    input  bpb_pkg::bpb_commit_t          commit,
    input  bpb_pkg::word_t [1:0]          slot_pc,
    output logic [1:0]                    slot_hit,
    output bpb_pkg::bpb_result_t [1:0]    slot_result
);

    localparam int NUM_LINES = 1 << `BPB_ENTRY_WIDTH;

    logic [`BPB_ENTRY_WIDTH-1:0]  commit_idx;               // line trained by the commit.
    logic [NUM_LINES-1:0]         line_wen;                 // one-hot write enables.
    logic [`BPB_ENTRY_WIDTH-1:0]  slot_idx [2];             // line read by each slot.

    // per-line lookup outputs, both slots.
    logic [1:0]                   line_hit    [NUM_LINES];
    bpb_pkg::bpb_result_t [1:0]   line_result [NUM_LINES];

    assign commit_idx  = commit.pc[`BPB_ENTRY_WIDTH + 1:2];

    // slot 1 may fall into the next line.
    assign slot_idx[0] = slot_pc[0][`BPB_ENTRY_WIDTH + 1:2];
    assign slot_idx[1] = slot_pc[1][`BPB_ENTRY_WIDTH + 1:2];

    for (genvar i = 0; i < NUM_LINES; i++)
    begin : g_line
        localparam logic [`BPB_ENTRY_WIDTH-1:0] LINE_IDX = i;

        assign line_wen[i] = commit_valid && (commit_idx == LINE_IDX);

        bpb_line u_line
        (
            .clk            (clk),
            .reset          (reset),
            .stall          (stall),
            .wen            (line_wen[i]),
            .pc_predict     (slot_pc),
            .commit         (commit),
            .hit_predict    (line_hit[i]),
            .result_predict (line_result[i])
        );
    end

    // each slot picks its own line.
    always_comb
    begin
        for (int s = 0; s < 2; s++)
        begin
            slot_hit[s]    = line_hit[slot_idx[s]][s];
            slot_result[s] = line_result[slot_idx[s]][s];
        end
    end

    // at most one line written per commit.
    wen_onehot: assert property (@(posedge clk) disable iff (!reset)
        $onehot0(line_wen));

endmodule

//--- bpb_defines.svh
`ifndef BPB_DEFINES_SVH
`define BPB_DEFINES_SVH

// Geometry of the direct-mapped branch prediction buffer.
// A fetch address splits into tag, index and byte offset.
//   [31 : BPB_ENTRY_WIDTH+2]   tag
//   [BPB_ENTRY_WIDTH+1 : 2]    line index
//   [1 : 0]                    byte offset, always zero for MIPS.

// index bits, 4 gives 16 lines.
`define BPB_ENTRY_WIDTH 4

// address bits above the index.
`define BPB_TAG_WIDTH (30 - `BPB_ENTRY_WIDTH)

// byte step between two fetch groups of two instructions.
`define BPB_FETCH_STEP 8

`endif

//--- bpb_line.sv
`timescale 1ns/1ps
`include "bpb_defines.svh"

module bpb_line
(
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          stall,
    input  logic                          wen,
    input  bpb_pkg::word_t [1:0]          pc_predict,
    input  bpb_pkg::bpb_commit_t          commit,
    output logic [1:0]                    hit_predict,
    output bpb_pkg::bpb_result_t [1:0]    result_predict
);

    logic                       valid;          // entry holds a branch.
    logic [`BPB_TAG_WIDTH-1:0]  tag;            // upper address bits of the branch.
    bpb_pkg::word_t             destpc;         // target captured at allocation.
    bpb_pkg::bpb_state_e        state;          // direction counter.

    logic [`BPB_TAG_WIDTH-1:0]  commit_tag;
    logic                       commit_hit;     // commit trains this branch.
    logic                       write_en;       // qualified write strobe.
    bpb_pkg::bpb_state_e        state_next;

    assign commit_tag = commit.pc[31:`BPB_ENTRY_WIDTH + 2];
    assign commit_hit = valid && (tag == commit_tag);
    assign write_en   = wen && !stall;

    // counter step for the resolved direction.
    always_comb
    begin
        state_next = state;
        case (state)
            bpb_pkg::ST_STRONG_NOT:
                state_next = commit.taken ? bpb_pkg::ST_WEAK_NOT : bpb_pkg::ST_STRONG_NOT;
            bpb_pkg::ST_WEAK_NOT:
                state_next = commit.taken ? bpb_pkg::ST_STRONG_TAKEN : bpb_pkg::ST_STRONG_NOT;
            bpb_pkg::ST_WEAK_TAKEN:
                state_next = commit.taken ? bpb_pkg::ST_STRONG_TAKEN : bpb_pkg::ST_STRONG_NOT;
            bpb_pkg::ST_STRONG_TAKEN:
                state_next = commit.taken ? bpb_pkg::ST_STRONG_TAKEN : bpb_pkg::ST_WEAK_TAKEN;
            default:
                state_next = state;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (!reset)
        begin
            valid <= 1'b0;
        end
        else if (write_en)
        begin
            valid <= 1'b1;
        end
    end

    // payload of the entry.
    always_ff @(posedge clk)
    begin
        if (write_en)
        begin
            if (!commit_hit)
            begin
                tag    <= commit_tag;               // allocate on miss.
                destpc <= commit.destpc;
                state  <= bpb_pkg::ST_STRONG_NOT;
            end
            else
            begin
                state <= state_next;                // train on hit.
            end
        end
    end

    // both slots compare against the same entry.
    for (genvar s = 0; s < 2; s++)
    begin : g_slot
        logic [`BPB_TAG_WIDTH-1:0] slot_tag;

        assign slot_tag                 = pc_predict[s][31:`BPB_ENTRY_WIDTH + 2];
        assign hit_predict[s]           = valid && (tag == slot_tag);
        assign result_predict[s].taken  = hit_predict[s] && state[1];
        assign result_predict[s].destpc = destpc;
    end

    // a stalled cycle must not touch the entry.
    stall_holds_entry: assert property (@(posedge clk) disable iff (!reset)
        stall |=> ($stable(valid) && (!valid || $stable(state))));

endmodule

//--- bpb_next_pc.sv
`timescale 1ns/1ps
`include "bpb_defines.svh"

module bpb_next_pc
(
    input  bpb_pkg::word_t                fetch_pc,
    input  logic [1:0]                    slot_hit,
    input  bpb_pkg::bpb_result_t [1:0]    slot_result,
    output bpb_pkg::word_t                next_pc,
    output logic                          redirect
);

    logic           slot0_taken;    // slot 0 redirects fetch.
    logic           slot1_taken;    // slot 1 redirects fetch.
    bpb_pkg::word_t seq_pc;         // fall-through fetch group.

    assign slot0_taken = slot_hit[0] && slot_result[0].taken;
    assign slot1_taken = slot_hit[1] && slot_result[1].taken;
    assign seq_pc      = fetch_pc + 32'(`BPB_FETCH_STEP);

    // the older instruction wins when both predict taken.
    always_comb
    begin
        if (slot0_taken)
        begin
            next_pc = slot_result[0].destpc;
        end
        else if (slot1_taken)
        begin
            next_pc = slot_result[1].destpc;
        end
        else
        begin
            next_pc = seq_pc;
        end
    end

    assign redirect = slot0_taken || slot1_taken;

endmodule

//--- bpb_pkg.sv
package bpb_pkg;

    // 32-bit address or instruction word.
    typedef logic [31:0] word_t;

    // prediction for one fetch slot.
    typedef struct packed
    {
        logic  taken;   // predicted taken.
        word_t destpc;  // stored branch target.
    } bpb_result_t;

    // resolved branch coming back from the commit stage.
    typedef struct packed
    {
        word_t pc;      // address of the branch.
        word_t destpc;  // resolved target.
        logic  taken;   // resolved direction.
    } bpb_commit_t;

    // two-bit saturating scheme.
    // the high bit is the prediction, so both taken states share bit 1.
    // a miss from a weak state falls all the way to strong-not.
    typedef enum logic [1:0]
    {
        ST_STRONG_NOT   = 2'b00,
        ST_WEAK_NOT     = 2'b01,
        ST_WEAK_TAKEN   = 2'b10,
        ST_STRONG_TAKEN = 2'b11
    } bpb_state_e;

endpackage

//--- bpb_top.sv
`timescale 1ns/1ps

module bpb_top
(
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          stall,
    input  logic                          commit_valid,
    input  bpb_pkg::bpb_commit_t          commit,
    input  bpb_pkg::word_t                fetch_pc,
    output logic [1:0]                    slot_hit,
    output bpb_pkg::bpb_result_t [1:0]    slot_result,
    output bpb_pkg::word_t                next_pc,
    output logic                          redirect
);

    bpb_pkg::word_t [1:0] slot_pc;  // addresses of the two issue slots.

    assign slot_pc[0] = fetch_pc;
    assign slot_pc[1] = fetch_pc + 32'd4;   // second instruction of the group.

    bpb_bank u_bank
    (
        .clk          (clk),
        .reset        (reset),
        .stall        (stall),
        .commit_valid (commit_valid),
        .commit       (commit),
        .slot_pc      (slot_pc),
        .slot_hit     (slot_hit),
        .slot_result  (slot_result)
    );

    // lookup and selection are combinational, same cycle as fetch_pc.
    bpb_next_pc u_next_pc
    (
        .fetch_pc    (fetch_pc),
        .slot_hit    (slot_hit),
        .slot_result (slot_result),
        .next_pc     (next_pc),
        .redirect    (redirect)
    );

endmodule

//--- tb.f
+incdir+.
bpb_pkg.sv
bpb_line.sv
bpb_bank.sv
bpb_next_pc.sv
bpb_top.sv
tb_bpb.sv

//--- tb_bpb.sv
`timescale 1ns/1ps
`include "bpb_defines.svh"

module tb_bpb;

    localparam int NUM_LINES = 1 << `BPB_ENTRY_WIDTH;

    logic                       clk;
    logic                       reset;
    logic                       stall;
    logic                       commit_valid;
    bpb_pkg::bpb_commit_t       commit;
    bpb_pkg::word_t             fetch_pc;
    logic [1:0]                 slot_hit;
    bpb_pkg::bpb_result_t [1:0] slot_result;
    bpb_pkg::word_t             next_pc;
    logic                       redirect;

    // reference model of the lines.
    logic                       valid_m [NUM_LINES];
    logic [`BPB_TAG_WIDTH-1:0]  tag_m   [NUM_LINES];
    bpb_pkg::word_t             dest_m  [NUM_LINES];
    bpb_pkg::bpb_state_e        state_m [NUM_LINES];

    logic [31:0]                lcg_state;
    int                         errors;

    bpb_top UUT
    (
        .clk          (clk),
        .reset        (reset),
        .stall        (stall),
        .commit_valid (commit_valid),
        .commit       (commit),
        .fetch_pc     (fetch_pc),
        .slot_hit     (slot_hit),
        .slot_result  (slot_result),
        .next_pc      (next_pc),
        .redirect     (redirect)
    );

    initial
    begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic bpb_pkg::word_t rand_addr();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return {lcg_state[31:2], 2'b00};    // word aligned.
    endfunction

    function automatic int idx_of(input bpb_pkg::word_t pc);
        return int'(pc[`BPB_ENTRY_WIDTH + 1:2]);
    endfunction

    // counter rule, a weak miss drops to strong-not.
    function automatic bpb_pkg::bpb_state_e step_state(input bpb_pkg::bpb_state_e st,
                                                      input logic taken);
        case (st)
            bpb_pkg::ST_STRONG_NOT:   return taken ? bpb_pkg::ST_WEAK_NOT : bpb_pkg::ST_STRONG_NOT;
            bpb_pkg::ST_WEAK_NOT:     return taken ? bpb_pkg::ST_STRONG_TAKEN : bpb_pkg::ST_STRONG_NOT;
            bpb_pkg::ST_STRONG_TAKEN: return taken ? bpb_pkg::ST_STRONG_TAKEN : bpb_pkg::ST_WEAK_TAKEN;
            default:                  return taken ? bpb_pkg::ST_STRONG_TAKEN : bpb_pkg::ST_STRONG_NOT;
        endcase
    endfunction

    function automatic logic model_hit(input bpb_pkg::word_t pc);
        return valid_m[idx_of(pc)] && (tag_m[idx_of(pc)] == pc[31:`BPB_ENTRY_WIDTH + 2]);
    endfunction

    task automatic fail_now();
        $display("Errors found");
        $fatal(1, "stopping at first mismatch");
    endtask

    task automatic check_hit(input string name, input logic [1:0] exp, input logic [1:0] act);
        if (act !== exp)
        begin
            $display("ERR %s: expected %b, actual %b", name, exp, act);
            errors++;
            fail_now();
        end
    endtask

    task automatic check_result(input string name, input bpb_pkg::bpb_result_t exp,
                                input bpb_pkg::bpb_result_t act);
        if (act !== exp)
        begin
            $display("ERR %s: expected %h, actual %h", name, exp, act);
            errors++;
            fail_now();
        end
    endtask

    task automatic check_word(input string name, input bpb_pkg::word_t exp,
                              input bpb_pkg::word_t act);
        if (act !== exp)
        begin
            $display("ERR %s: expected %h, actual %h", name, exp, act);
            errors++;
            fail_now();
        end
    endtask

    // one commit, model follows only when not stalled.
    task automatic do_commit(input bpb_pkg::word_t pc, input bpb_pkg::word_t dest,
                             input logic taken, input logic stl);
        int i;
        i = idx_of(pc);
        @(posedge clk);
        commit_valid <= 1'b1;
        commit       <= '{pc: pc, destpc: dest, taken: taken};
        stall        <= stl;
        @(posedge clk);
        commit_valid <= 1'b0;
        stall        <= 1'b0;
        if (!stl)
        begin
            if (model_hit(pc))
            begin
                state_m[i] = step_state(state_m[i], taken);
            end
            else
            begin
                valid_m[i] = 1'b1;
                tag_m[i]   = pc[31:`BPB_ENTRY_WIDTH + 2];
                dest_m[i]  = dest;
                state_m[i] = bpb_pkg::ST_STRONG_NOT;
            end
        end
    endtask

    // present pc and compare all lookup outputs with the model.
    task automatic lookup(input string name, input bpb_pkg::word_t pc);
        bpb_pkg::word_t       spc [2];
        bpb_pkg::bpb_result_t exp_res [2];
        logic [1:0]           exp_hit;
        logic [1:0]           exp_taken;
        bpb_pkg::word_t       exp_next;
        int                   i;
        spc[0] = pc;
        spc[1] = pc + 32'd4;
        for (int s = 0; s < 2; s++)
        begin
            i = idx_of(spc[s]);
            exp_hit[s]           = model_hit(spc[s]);
            exp_res[s].taken     = exp_hit[s] && state_m[i][1];
            exp_res[s].destpc    = dest_m[i];
            exp_taken[s]         = exp_res[s].taken;
        end
        if (exp_taken[0])
            exp_next = exp_res[0].destpc;
        else if (exp_taken[1])
            exp_next = exp_res[1].destpc;
        else
            exp_next = pc + 32'd8;
        @(posedge clk);
        fetch_pc <= pc;
        @(negedge clk);                          // outputs settled.
        check_hit(name, exp_hit, slot_hit);
        check_hit(name, exp_taken, {slot_result[1].taken, slot_result[0].taken});
        for (int s = 0; s < 2; s++)
        begin
            if (exp_hit[s])
                check_result(name, exp_res[s], slot_result[s]);
        end
        check_word(name, exp_next, next_pc);
        check_hit(name, {1'b0, |exp_taken}, {1'b0, redirect});
    endtask

    task automatic wait_reset_release();
        int cnt;
        cnt = 0;
        while (reset !== 1'b1)
        begin
            @(posedge clk);
            cnt++;
            if (cnt > 20)
            begin
                $display("reset was never released");
                fail_now();
            end
        end
    endtask

    task automatic test_reset_miss();
        bpb_pkg::word_t pc;
        for (int n = 0; n < 8; n++)
        begin
            pc = rand_addr();
            lookup("test_reset_miss", pc);
            check_hit("test_reset_miss", 2'b00, slot_hit);
            check_word("test_reset_miss", pc + 32'd8, next_pc);
        end
    endtask

    task automatic test_allocate(input bpb_pkg::word_t a);
        do_commit(a, 32'h0040_1000, 1'b1, 1'b0);
        lookup("test_allocate", a);
        check_hit("test_allocate", {model_hit(a + 32'd4), 1'b1}, slot_hit);
        lookup("test_allocate", a - 32'd4);
        check_hit("test_allocate", {1'b1, model_hit(a - 32'd4)}, slot_hit);
    endtask

    task automatic test_counter_walk(input bpb_pkg::word_t b);
        logic [6:0] outcome;
        outcome = 7'b1001011;                    // t t n t n n t, lsb first.
        do_commit(b, 32'h0080_2000, 1'b0, 1'b0);
        lookup("test_counter_walk", b);
        for (int n = 0; n < 7; n++)
        begin
            do_commit(b, 32'h0080_2000, outcome[n], 1'b0);
            lookup("test_counter_walk", b);
        end
    endtask

    task automatic test_replace(input bpb_pkg::word_t a);
        bpb_pkg::word_t c;
        c = a ^ (32'd1 << (`BPB_ENTRY_WIDTH + 2));   // same index, new tag.
        do_commit(c, 32'h00c0_3000, 1'b1, 1'b0);
        lookup("test_replace", a);
        check_hit("test_replace", {model_hit(a + 32'd4), 1'b0}, slot_hit);
        lookup("test_replace", c);
        check_hit("test_replace", {model_hit(c + 32'd4), 1'b1}, slot_hit);
    endtask

    task automatic test_stall(input bpb_pkg::word_t b);
        bpb_pkg::word_t d;
        d = rand_addr();
        do_commit(d, 32'h0100_4000, 1'b1, 1'b1);
        do_commit(b, 32'h0100_5000, 1'b1, 1'b1);
        do_commit(b, 32'h0100_5000, 1'b0, 1'b1);
        lookup("test_stall", d);
        lookup("test_stall", b);
    endtask

    task automatic train(input bpb_pkg::word_t pc, input bpb_pkg::word_t dest, input logic taken);
        do_commit(pc, dest, 1'b0, 1'b0);
        do_commit(pc, dest, taken, 1'b0);
        do_commit(pc, dest, taken, 1'b0);   // ends strong in the given direction.
    endtask

    task automatic test_next_pc();
        bpb_pkg::word_t f;
        for (int mode = 0; mode < 3; mode++)
        begin
            f = rand_addr();
            train(f, 32'h0200_0000 + f[15:0], mode != 1);
            train(f + 32'd4, 32'h0300_0000 + f[15:0], mode != 0);
            lookup("test_next_pc", f);
            check_word("test_next_pc", (mode == 1) ? 32'h0300_0000 + f[15:0]
                                                   : 32'h0200_0000 + f[15:0], next_pc);
            check_hit("test_next_pc", 2'b01, {1'b0, redirect});
        end
    endtask

    initial
    begin
        bpb_pkg::word_t a;
        bpb_pkg::word_t b;
        errors       = 0;
        lcg_state    = 32'd90;
        reset        = 1'b0;
        stall        = 1'b0;
        commit_valid = 1'b0;
        commit       = '0;
        fetch_pc     = '0;
        for (int i = 0; i < NUM_LINES; i++)
            valid_m[i] = 1'b0;
        repeat (3) @(posedge clk);
        reset <= 1'b1;
        wait_reset_release();
        test_reset_miss();
        a = rand_addr();
        b = a + 32'd24;                          // a different line from a.
        test_allocate(a);
        test_counter_walk(b);
        test_replace(a);
        test_stall(b);
        test_next_pc();
        if (errors == 0)
        begin
            $display("No errors");
        end
        else
        begin
            $display("Errors found");
        end
        $finish;
    end

endmodule
